/* common/readout_params.svh */
`ifndef READOUT_PARAMS_SVH
`define READOUT_PARAMS_SVH

// fifo depth in 32-bit words
`define FIFO_DEPTH 1024

`define BUS_ADDR_WIDTH 32

// thresholds in percent of the fifo depth
`define ALMOST_FULL_PCT 95
`define ALMOST_EMPTY_PCT 5

`endif

/* common/hit_format_pkg.sv */
`default_nettype none

package hit_format_pkg;

    localparam int FINE_TS_BITS = 11;
    localparam int EPOCH_BITS   = 21; // timestamp bits 31..11

    typedef struct packed {
        logic                    is_tstamp; // 0 for a hit
        logic [6:0]              col;
        logic [8:0]              row;
        logic [3:0]              tot;
        logic [FINE_TS_BITS-1:0] fine_ts;
    } hit_word_t;

    typedef struct packed {
        logic                  is_tstamp; // 1 for a timestamp
        logic [9:0]            pad;
        logic [EPOCH_BITS-1:0] epoch;
    } tstamp_word_t;

    // top bit picks the view
    typedef union packed {
        hit_word_t    hit;
        tstamp_word_t ts;
    } data_word_u;

endpackage

`default_nettype wire

/* common/fifo_regs_pkg.sv */
`default_nettype none

package fifo_regs_pkg;

    localparam int REG_ADDR_BITS = 3;
    localparam int REG_DATA_BITS = 8;

    // write meaning / read meaning share an address
    typedef enum logic [REG_ADDR_BITS-1:0] {
        REG_SOFT_RST = 3'd0, // write only
        REG_AF_SIZE0 = 3'd1, // almost-full value / size byte 0
        REG_AE_SIZE1 = 3'd2, // almost-empty value / size byte 1
        REG_SIZE2    = 3'd3,
        REG_RD_ERR   = 3'd4
    } reg_addr_e;

endpackage

`default_nettype wire

/* bram_fifo/generic_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module generic_fifo #(
    parameter int DATA_SIZE = 32,
    parameter int DEPTH     = 1024
) (
    input  wire                  BUS_CLK,
    input  wire                  RST,
    input  wire                  write,
    input  wire                  read,
    input  wire  [DATA_SIZE-1:0] data_in,
    output logic                 full,
    output logic                 empty,
    output logic [DATA_SIZE-1:0] data_out,
    output logic [31:0]          size
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DATA_SIZE-1:0] mem [DEPTH];
    logic [AW-1:0] wr_ptr, rd_ptr;
    logic do_wr, do_rd;

    assign full     = (size == 32'(DEPTH));
    assign empty    = (size == 32'd0);
    assign do_wr    = write && !full;  // dropped when full
    assign do_rd    = read && !empty;
    assign data_out = mem[rd_ptr];     // head word falls through

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= data_in;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            size   <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   size <= size + 32'd1;
                2'b01:   size <= size - 32'd1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* bram_fifo/bram_fifo_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "readout_params.svh"

module bram_fifo_core #(
    parameter int DEPTH                       = `FIFO_DEPTH,
    parameter int FIFO_ALMOST_FULL_THRESHOLD  = `ALMOST_FULL_PCT,
    parameter int FIFO_ALMOST_EMPTY_THRESHOLD = `ALMOST_EMPTY_PCT,
    parameter int ABUSWIDTH                   = `BUS_ADDR_WIDTH
) (
    input  wire                  BUS_CLK,
    input  wire                  RST,
    input  wire  [ABUSWIDTH-1:0] bus_add,
    input  wire  [7:0]           bus_data_in,
    input  wire                  bus_rd,
    input  wire                  bus_wr,
    output logic [7:0]           bus_data_out,
    input  wire                  bus_rd_data,
    output logic [31:0]          bus_data_out_data,
    input  wire                  bus_wr_data,
    input  wire  [31:0]          bus_data_in_data,
    output logic                 fifo_read_next_out,
    input  wire                  fifo_empty_in,
    input  wire  [31:0]          fifo_data,
    output logic                 fifo_not_empty,
    output logic                 fifo_full,
    output logic                 fifo_near_full,
    output logic                 fifo_read_error
);
    import fifo_regs_pkg::*;

    logic addr_in_map, soft_rst, rst_int;
    reg_addr_e reg_sel;
    logic [REG_DATA_BITS-1:0] almost_full_value, almost_empty_value;
    logic [REG_DATA_BITS-1:0] read_error_cnt;
    logic [31:0] fifo_size, size_bytes;
    logic [31:0] af_level, ae_level; // hysteresis points in words
    logic buf_full, buf_empty;
    logic [31:0] buf_head;

    assign addr_in_map = (bus_add[ABUSWIDTH-1:REG_ADDR_BITS] == '0);
    assign reg_sel     = reg_addr_e'(bus_add[REG_ADDR_BITS-1:0]);
    assign soft_rst    = bus_wr && addr_in_map && (reg_sel == REG_SOFT_RST);
    assign rst_int     = RST || soft_rst;

    // thresholds count in 1/256 of the depth
    always_ff @(posedge BUS_CLK) begin
        if (rst_int) begin
            almost_full_value  <= 8'(255 * FIFO_ALMOST_FULL_THRESHOLD / 100);
            almost_empty_value <= 8'(255 * FIFO_ALMOST_EMPTY_THRESHOLD / 100);
        end else if (bus_wr && addr_in_map) begin
            case (reg_sel)
                REG_AF_SIZE0: almost_full_value  <= bus_data_in;
                REG_AE_SIZE1: almost_empty_value <= bus_data_in;
                default:      ;
            endcase
        end
    end

    assign size_bytes = fifo_size << 2;

    always_ff @(posedge BUS_CLK) begin
        if (bus_rd) begin
            if (!addr_in_map) begin
                bus_data_out <= '0;
            end else begin
                case (reg_sel)
                    REG_AF_SIZE0: bus_data_out <= size_bytes[7:0];
                    REG_AE_SIZE1: bus_data_out <= size_bytes[15:8];
                    REG_SIZE2:    bus_data_out <= size_bytes[23:16];
                    REG_RD_ERR:   bus_data_out <= read_error_cnt;
                    default:      bus_data_out <= '0;
                endcase
            end
        end
    end

    generic_fifo #(
        .DATA_SIZE(32),
        .DEPTH    (DEPTH)
    ) u_buf (
        .BUS_CLK (BUS_CLK),
        .RST     (rst_int),
        .write   (!fifo_empty_in || bus_wr_data),
        .read    (bus_rd_data),
        .data_in (bus_wr_data ? bus_data_in_data : fifo_data), // host word wins
        .full    (buf_full),
        .empty   (buf_empty),
        .data_out(buf_head),
        .size    (fifo_size)
    );

    assign fifo_read_next_out = !buf_full;
    assign fifo_not_empty     = !buf_empty;
    assign fifo_full          = buf_full;
    assign fifo_read_error    = (read_error_cnt != '0);

    always_ff @(posedge BUS_CLK) begin
        bus_data_out_data <= buf_head;
    end

    always_ff @(posedge BUS_CLK) begin
        if (rst_int)
            read_error_cnt <= '0;
        else if (buf_empty && bus_rd_data && read_error_cnt != 8'hff)
            read_error_cnt <= read_error_cnt + 8'd1;
    end

    assign af_level = ((32'(almost_full_value) + 32'd1) * 32'(DEPTH)) >> 8;
    assign ae_level = ((32'(almost_empty_value) + 32'd1) * 32'(DEPTH)) >> 8;

    always_ff @(posedge BUS_CLK) begin
        if (rst_int)
            fifo_near_full <= 1'b0;
        else if (fifo_size >= af_level || almost_full_value == '0)
            fifo_near_full <= 1'b1;
        else if ((fifo_size <= ae_level && almost_empty_value != '0) || fifo_size == 32'd0)
            fifo_near_full <= 1'b0; // else hold
    end

endmodule

`default_nettype wire

/* rtl/hit_source.sv */
`timescale 1ns/10ps
`default_nettype none

module hit_source (
    input  wire                        BUS_CLK,
    input  wire                        RST,
    input  wire                        hit_in_valid,
    input  wire  [6:0]                 hit_col,
    input  wire  [8:0]                 hit_row,
    input  wire  [3:0]                 hit_tot,
    input  wire                        near_full,
    input  wire                        read_next,
    output logic                       src_empty,
    output hit_format_pkg::data_word_u src_data,
    output logic [15:0]                drop_count
);
    import hit_format_pkg::*;

    localparam int QDEPTH = 4;

    logic [31:0] ts_cnt; // free running
    hit_word_t q_hit [QDEPTH];
    logic [EPOCH_BITS-1:0] q_epoch [QDEPTH];
    logic [$clog2(QDEPTH)-1:0] wr_ptr, rd_ptr;
    logic [$clog2(QDEPTH+1)-1:0] q_count;
    logic [EPOCH_BITS-1:0] last_epoch;
    logic epoch_sent; // low until the first timestamp word goes out
    logic q_full, push, pop, xfer, need_ts;

    assign q_full    = (q_count == QDEPTH);
    assign src_empty = (q_count == 0);
    assign push      = hit_in_valid && !q_full && !near_full;
    assign xfer      = read_next && !src_empty;
    assign need_ts   = !epoch_sent || (q_epoch[rd_ptr] != last_epoch);
    assign pop       = xfer && !need_ts; // timestamp word leaves the hit queued

    always_comb begin
        if (need_ts) begin
            src_data.ts.is_tstamp = 1'b1;
            src_data.ts.pad       = '0;
            src_data.ts.epoch     = q_epoch[rd_ptr];
        end else begin
            src_data.hit = q_hit[rd_ptr];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            q_hit[wr_ptr].is_tstamp <= 1'b0;
            q_hit[wr_ptr].col       <= hit_col;
            q_hit[wr_ptr].row       <= hit_row;
            q_hit[wr_ptr].tot       <= hit_tot;
            q_hit[wr_ptr].fine_ts   <= ts_cnt[FINE_TS_BITS-1:0];
            q_epoch[wr_ptr]         <= ts_cnt[FINE_TS_BITS +: EPOCH_BITS];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            ts_cnt     <= '0;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_count    <= '0;
            last_epoch <= '0;
            epoch_sent <= 1'b0;
            drop_count <= '0;
        end else begin
            ts_cnt <= ts_cnt + 32'd1;
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: ;
            endcase
            if (xfer && need_ts) begin
                last_epoch <= q_epoch[rd_ptr];
                epoch_sent <= 1'b1;
            end
            if (hit_in_valid && !push && drop_count != 16'hffff)
                drop_count <= drop_count + 16'd1; // saturating
        end
    end

endmodule

`default_nettype wire

/* rtl/hit_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module hit_decoder (
    input  wire                        BUS_CLK,
    input  wire                        RST,
    input  wire                        not_empty,
    input  wire hit_format_pkg::data_word_u data_in,
    input  wire                        hit_ready,
    output logic                       rd_data,
    output logic                       hit_valid,
    output logic [6:0]                 out_col,
    output logic [8:0]                 out_row,
    output logic [3:0]                 out_tot,
    output logic [31:0]                out_time
);
    import hit_format_pkg::*;

    logic inflight;   // data_in holds the word read last cycle
    logic pend_valid; // word parked while the output was busy
    data_word_u pend_word, cur_word;
    logic word_held, out_free, consume;
    logic [EPOCH_BITS-1:0] epoch;

    assign word_held = inflight || pend_valid;
    assign cur_word  = pend_valid ? pend_word : data_in;
    assign out_free  = !hit_valid || hit_ready;
    // timestamp words never need the output register
    assign consume   = word_held && (cur_word.ts.is_tstamp || out_free);
    assign rd_data   = not_empty && !(word_held && !out_free);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            inflight   <= 1'b0;
            pend_valid <= 1'b0;
            hit_valid  <= 1'b0;
            epoch      <= '0;
        end else begin
            inflight   <= rd_data;
            pend_valid <= word_held && !consume;
            if (consume && cur_word.ts.is_tstamp)
                epoch <= cur_word.ts.epoch;
            if (consume && !cur_word.hit.is_tstamp)
                hit_valid <= 1'b1;
            else if (hit_ready)
                hit_valid <= 1'b0;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (!pend_valid)
            pend_word <= data_in;
        if (consume && !cur_word.hit.is_tstamp) begin
            out_col  <= cur_word.hit.col;
            out_row  <= cur_word.hit.row;
            out_tot  <= cur_word.hit.tot;
            out_time <= {epoch, cur_word.hit.fine_ts}; // full hit time
        end
    end

endmodule

`default_nettype wire

/* rtl/readout_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "readout_params.svh"

module readout_top (
    input  wire                       BUS_CLK,
    input  wire                       RST,
    input  wire                       hit_in_valid,
    input  wire  [6:0]                hit_col,
    input  wire  [8:0]                hit_row,
    input  wire  [3:0]                hit_tot,
    input  wire  [`BUS_ADDR_WIDTH-1:0] bus_add,
    input  wire  [7:0]                bus_data_in,
    input  wire                       bus_wr,
    input  wire                       bus_rd,
    input  wire                       bus_wr_data,
    input  wire  [31:0]               bus_data_in_data,
    output logic [7:0]                bus_data_out,
    output logic                      hit_valid,
    input  wire                       hit_ready,
    output logic [6:0]                out_col,
    output logic [8:0]                out_row,
    output logic [3:0]                out_tot,
    output logic [31:0]               out_time,
    output logic [15:0]               drop_count,
    output logic                      fifo_full,
    output logic                      fifo_near_full,
    output logic                      fifo_read_error
);
    import hit_format_pkg::*;

    data_word_u src_word, fifo_word;
    logic src_empty, read_next;
    logic rd_data, not_empty;

    hit_source u_source (
        .BUS_CLK     (BUS_CLK),
        .RST         (RST),
        .hit_in_valid(hit_in_valid),
        .hit_col     (hit_col),
        .hit_row     (hit_row),
        .hit_tot     (hit_tot),
        .near_full   (fifo_near_full), // drops hits while set
        .read_next   (read_next),
        .src_empty   (src_empty),
        .src_data    (src_word),
        .drop_count  (drop_count)
    );

    bram_fifo_core #(
        .DEPTH                      (`FIFO_DEPTH),
        .FIFO_ALMOST_FULL_THRESHOLD (`ALMOST_FULL_PCT),
        .FIFO_ALMOST_EMPTY_THRESHOLD(`ALMOST_EMPTY_PCT),
        .ABUSWIDTH                  (`BUS_ADDR_WIDTH)
    ) u_fifo (
        .BUS_CLK           (BUS_CLK),
        .RST               (RST),
        .bus_add           (bus_add),
        .bus_data_in       (bus_data_in),
        .bus_rd            (bus_rd),
        .bus_wr            (bus_wr),
        .bus_data_out      (bus_data_out),
        .bus_rd_data       (rd_data),
        .bus_data_out_data (fifo_word),
        .bus_wr_data       (bus_wr_data),
        .bus_data_in_data  (bus_data_in_data),
        .fifo_read_next_out(read_next),
        .fifo_empty_in     (src_empty),
        .fifo_data         (src_word),
        .fifo_not_empty    (not_empty),
        .fifo_full         (fifo_full),
        .fifo_near_full    (fifo_near_full),
        .fifo_read_error   (fifo_read_error)
    );

    hit_decoder u_decoder (
        .BUS_CLK  (BUS_CLK),
        .RST      (RST),
        .not_empty(not_empty),
        .data_in  (fifo_word),
        .hit_ready(hit_ready),
        .rd_data  (rd_data),
        .hit_valid(hit_valid),
        .out_col  (out_col),
        .out_row  (out_row),
        .out_tot  (out_tot),
        .out_time (out_time)
    );

endmodule

`default_nettype wire

/* sim/tb_readout_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "readout_params.svh"

module tb_readout_top;
    import fifo_regs_pkg::*;

    localparam int CLK_PERIOD  = 10;
    localparam int TEST_CYCLES = 6000; // rough length of all tests together
    localparam logic [7:0] AF_DEF = 8'(255 * `ALMOST_FULL_PCT / 100);
    localparam logic [7:0] AE_DEF = 8'(255 * `ALMOST_EMPTY_PCT / 100);
    localparam int RDY_LOW    = 0;
    localparam int RDY_HIGH   = 1;
    localparam int RDY_RANDOM = 2;

    logic BUS_CLK, RST;
    logic hit_in_valid, hit_ready, hit_valid;
    logic [6:0] hit_col, out_col;
    logic [8:0] hit_row, out_row;
    logic [3:0] hit_tot, out_tot;
    logic [31:0] out_time, bus_data_in_data;
    logic [`BUS_ADDR_WIDTH-1:0] bus_add;
    logic [7:0] bus_data_in, bus_data_out;
    logic bus_wr, bus_rd, bus_wr_data;
    logic [15:0] drop_count;
    logic fifo_full, fifo_near_full, fifo_read_error;

    logic [51:0] exp_q[$]; // col, row, tot, time
    logic [51:0] want;
    logic [31:0] ts_model, words, af_lvl, ae_lvl;
    logic [20:0] last_epoch;
    logic [7:0] af_val, ae_val;
    logic [15:0] drop_exp;
    logic nf_exp, soft_wr, wr_in, rd_out;
    int errors, n_checked, epoch_changes, ts_words, ready_mode;
    string test_name;

    readout_top u_dut (
        .BUS_CLK(BUS_CLK), .RST(RST), .hit_in_valid(hit_in_valid),
        .hit_col(hit_col), .hit_row(hit_row), .hit_tot(hit_tot),
        .bus_add(bus_add), .bus_data_in(bus_data_in), .bus_wr(bus_wr), .bus_rd(bus_rd),
        .bus_wr_data(bus_wr_data), .bus_data_in_data(bus_data_in_data),
        .bus_data_out(bus_data_out), .hit_valid(hit_valid), .hit_ready(hit_ready),
        .out_col(out_col), .out_row(out_row), .out_tot(out_tot), .out_time(out_time),
        .drop_count(drop_count), .fifo_full(fifo_full), .fifo_near_full(fifo_near_full),
        .fifo_read_error(fifo_read_error)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;
    end

    initial begin
        #(TEST_CYCLES * 4 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("*** TEST FAILED ***");
        $finish;
    end

    // fifo word count and near-full hysteresis from the interface transfers
    assign soft_wr = bus_wr && bus_add == 32'(REG_SOFT_RST);
    assign wr_in   = bus_wr_data || (u_dut.read_next && !u_dut.src_empty);
    assign rd_out  = u_dut.rd_data && u_dut.not_empty;
    assign af_lvl  = ((32'(af_val) + 32'd1) * `FIFO_DEPTH) / 256;
    assign ae_lvl  = ((32'(ae_val) + 32'd1) * `FIFO_DEPTH) / 256;

    always @(posedge BUS_CLK) begin
        if (RST || soft_wr) begin
            words  <= '0;
            nf_exp <= 1'b0;
            af_val <= AF_DEF;
            ae_val <= AE_DEF;
        end else begin
            words <= words + 32'(wr_in) - 32'(rd_out);
            if (bus_wr && bus_add == 32'(REG_AF_SIZE0))
                af_val <= bus_data_in;
            if (bus_wr && bus_add == 32'(REG_AE_SIZE1))
                ae_val <= bus_data_in;
            if (words >= af_lvl || af_val == 8'd0)
                nf_exp <= 1'b1;
            else if ((words <= ae_lvl && ae_val != 8'd0) || words == 32'd0)
                nf_exp <= 1'b0;
        end
    end

    // hit timestamps, drops and output compare
    always @(posedge BUS_CLK) begin
        if (RST) begin
            ts_model   <= '0;
            drop_exp   <= '0;
            last_epoch <= '0;
        end else begin
            assert (fifo_near_full == nf_exp) else begin
                errors++;
                $display("error %s: near_full expected %0b actual %0b",
                         test_name, nf_exp, fifo_near_full);
            end
            assert (drop_count == drop_exp) else begin
                errors++;
                $display("error %s: drop_count expected %0d actual %0d",
                         test_name, drop_exp, drop_count);
            end
            assert (!fifo_full && !fifo_read_error) else begin
                errors++;
                $display("%s: fifo went full or flagged a read error", test_name);
            end
            if (hit_valid && hit_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: a hit came out while none was expected", test_name);
                end else begin
                    want = exp_q.pop_front();
                    n_checked++;
                    assert ({out_col, out_row, out_tot, out_time} == want) else begin
                        errors++;
                        $display("error %s: hit expected %h actual %h", test_name, want,
                                 {out_col, out_row, out_tot, out_time});
                    end
                end
            end
            if (u_dut.read_next && !u_dut.src_empty && u_dut.src_word.ts.is_tstamp)
                ts_words++; // timestamp word entering the fifo
            ts_model <= ts_model + 32'd1;
            if (hit_in_valid && nf_exp) begin
                drop_exp <= drop_exp + 16'd1;
            end else if (hit_in_valid) begin
                exp_q.push_back({hit_col, hit_row, hit_tot, ts_model});
                if (ts_model[31:11] != last_epoch)
                    epoch_changes++;
                last_epoch <= ts_model[31:11];
            end
        end
    end

    assert property (@(posedge BUS_CLK) disable iff (RST)
        hit_valid && !hit_ready |=> hit_valid && $stable({out_col, out_row, out_tot, out_time}))
    else begin
        errors++;
        $display("%s: output hit changed while hit_ready was low", test_name);
    end

    always @(posedge BUS_CLK) begin
        case (ready_mode)
            RDY_LOW:  hit_ready <= 1'b0;
            RDY_HIGH: hit_ready <= 1'b1;
            default:  hit_ready <= 1'($urandom % 2);
        endcase
    end

    task automatic send_hit(input logic [6:0] col, input logic [8:0] row,
                            input logic [3:0] tot);
        @(posedge BUS_CLK);
        hit_in_valid <= 1'b1;
        hit_col      <= col;
        hit_row      <= row;
        hit_tot      <= tot;
        @(posedge BUS_CLK);
        hit_in_valid <= 1'b0;
    endtask

    task automatic inject_word(input logic [31:0] word);
        @(posedge BUS_CLK);
        bus_wr_data      <= 1'b1;
        bus_data_in_data <= word;
        @(posedge BUS_CLK);
        bus_wr_data <= 1'b0;
    endtask

    task automatic write_reg(input reg_addr_e addr, input logic [7:0] value);
        @(posedge BUS_CLK);
        bus_wr      <= 1'b1;
        bus_add     <= 32'(addr);
        bus_data_in <= value;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e addr, output logic [7:0] value);
        @(posedge BUS_CLK);
        bus_rd  <= 1'b1;
        bus_add <= 32'(addr);
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK);
        value = bus_data_out; // registered one cycle after bus_rd
    endtask

    task automatic read_size(output logic [23:0] bytes);
        logic [7:0] b0, b1, b2;
        read_reg(REG_AF_SIZE0, b0);
        read_reg(REG_AE_SIZE1, b1);
        read_reg(REG_SIZE2, b2);
        bytes = {b2, b1, b0};
    endtask

    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d hits still missing after %0d cycles",
                     test_name, exp_q.size(), max_cycles);
        end
    endtask

    task automatic wait_output(input int max_cycles);
        int n;
        n = 0;
        while (!hit_valid && n < max_cycles) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (!hit_valid) begin
            errors++;
            $display("%s: no decoded hit appeared within %0d cycles", test_name, max_cycles);
        end
    endtask

    initial begin : main
        int i;
        logic [23:0] size;
        logic [7:0] rd_err;
        void'($urandom(32'hd3c5));
        RST = 1'b1;
        hit_in_valid = 1'b0;
        hit_col = '0;
        hit_row = '0;
        hit_tot = '0;
        bus_add = '0;
        bus_data_in = '0;
        bus_wr = 1'b0;
        bus_rd = 1'b0;
        bus_wr_data = 1'b0;
        bus_data_in_data = '0;
        hit_ready = 1'b0;
        ready_mode = RDY_LOW;
        errors = 0;
        n_checked = 0;
        epoch_changes = 0;
        ts_words = 0;
        test_name = "reset";
        repeat (8) @(posedge BUS_CLK);
        RST <= 1'b0;

        // random stream under random back-pressure
        test_name = "stream";
        ready_mode <= RDY_RANDOM;
        for (i = 0; i < 80; i++) begin
            send_hit(7'($urandom), 9'($urandom), 4'($urandom));
            repeat ($urandom % 39) @(posedge BUS_CLK);
        end

        // burst across an epoch boundary
        test_name = "epoch";
        @(negedge BUS_CLK);
        while (ts_model[10:0] != 11'd2040)
            @(negedge BUS_CLK);
        epoch_changes = 0;
        ts_words = 0;
        for (i = 0; i < 12; i++)
            send_hit(7'($urandom), 9'($urandom), 4'($urandom));
        wait_drained(2000);
        assert (epoch_changes > 0) else begin
            errors++;
            $display("%s: no hit landed in a new epoch", test_name);
        end
        assert (ts_words == epoch_changes) else begin
            errors++;
            $display("error %s: timestamp words expected %0d actual %0d",
                     test_name, epoch_changes, ts_words);
        end

        // decoder stalled with two hits, then host words fill the fifo
        test_name = "registers";
        ready_mode <= RDY_LOW;
        send_hit(7'h11, 9'h022, 4'h3);
        send_hit(7'h12, 9'h044, 4'h5);
        wait_output(100);
        repeat (4) @(posedge BUS_CLK);
        for (i = 0; i < 70; i++)
            inject_word(32'(i) & 32'h7fff_ffff); // never decoded, lost at soft reset
        read_size(size);
        assert (size == 24'(words * 4)) else begin
            errors++;
            $display("error %s: size expected %0d actual %0d", test_name, words * 4, size);
        end
        read_reg(REG_RD_ERR, rd_err);
        assert (rd_err == 8'd0) else begin
            errors++;
            $display("error %s: read errors expected 0 actual %0d", test_name, rd_err);
        end
        write_reg(REG_SOFT_RST, 8'd0);
        read_size(size);
        assert (size == 24'd0) else begin
            errors++;
            $display("error %s: size after soft reset expected 0 actual %0d", test_name, size);
        end
        ready_mode <= RDY_RANDOM;
        wait_drained(500);

        // small thresholds, stalled output
        test_name = "near_full";
        write_reg(REG_AF_SIZE0, 8'd3);
        write_reg(REG_AE_SIZE1, 8'd1);
        ready_mode <= RDY_LOW;
        for (i = 0; i < 40; i++)
            send_hit(7'($urandom), 9'($urandom), 4'($urandom));
        @(negedge BUS_CLK);
        assert (fifo_near_full && drop_exp != 16'd0) else begin
            errors++;
            $display("%s: near_full never rose or no hit was dropped", test_name);
        end
        ready_mode <= RDY_HIGH;
        wait_drained(500);
        write_reg(REG_SOFT_RST, 8'd0); // back to default thresholds

        // host word decoded with the current epoch
        test_name = "inject";
        @(negedge BUS_CLK);
        exp_q.push_back({7'h2a, 9'h11b, 4'h9, last_epoch, 11'h5a5});
        inject_word({1'b0, 7'h2a, 9'h11b, 4'h9, 11'h5a5});
        wait_drained(200);

        repeat (10) @(posedge BUS_CLK);
        $display("summary: %0d errors, %0d hits checked, %0d hits dropped",
                 errors, n_checked, drop_exp);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/hit_format_pkg.sv
common/fifo_regs_pkg.sv
bram_fifo/generic_fifo.sv
bram_fifo/bram_fifo_core.sv
rtl/hit_source.sv
rtl/hit_decoder.sv
rtl/readout_top.sv
sim/tb_readout_top.sv

/* Bender.yml */
package:
  name: pixel_readout

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/hit_format_pkg.sv
      - common/fifo_regs_pkg.sv
      - bram_fifo/generic_fifo.sv
      - bram_fifo/bram_fifo_core.sv
      - rtl/hit_source.sv
      - rtl/hit_decoder.sv
      - rtl/readout_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_readout_top.sv
